/* vlog.f */
common/rf_pkg.sv
rf_ram/rf_ram.sv
verilog/hazard_tracker.sv
verilog/operand_select.sv
verilog/rf_bypass_top.sv
tb/rf_bypass_properties.sv
tb/tb_rf_bypass.sv

/* Makefile */
# Verilator build and run for the operand register file testbench

TOP := tb_rf_bypass
LOG := sim.log

all: run

build:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean

/* tb/tb_rf_bypass.sv */
// Testbench for the operand register file with bypassing.
// Runs a four-slot software model of decode, execute, ctrl and writeback,
// keeps an architectural register scoreboard and checks both execute
// operands in the cycle after every decode advance and over stalls.

module tb_rf_bypass;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int AW = rf_pkg::RF_ADDR_WIDTH_DEF;
   localparam int RW = rf_pkg::RF_WORDS_DEF;
   localparam int OW = rf_pkg::OPERAND_WIDTH_DEF;

   // Global limit on simulated time
   localparam time RUN_LIMIT = 1ms;

   logic          clk;
   logic          rst;
   logic          padv_decode_i;
   logic          decode_valid_i;
   logic          pipeline_flush_i;
   logic [AW-1:0] decode_rfa_adr_i;
   logic [AW-1:0] decode_rfb_adr_i;
   logic [AW-1:0] execute_rfd_adr_i;
   logic          execute_rf_wb_i;
   logic [AW-1:0] ctrl_rfd_adr_i;
   logic          ctrl_rf_wb_i;
   logic [AW-1:0] wb_rfd_adr_i;
   logic          wb_rf_wb_i;
   logic [OW-1:0] ctrl_alu_result_i;
   logic [OW-1:0] wb_result_i;
   logic [OW-1:0] execute_rfa_o;
   logic [OW-1:0] execute_rfb_o;

   integer seed;
   int     errors;
   int     tests_passed;
   int     tests_failed;

   // Model copy of the flushing window
   bit     flushing_m;

   // Architectural registers
   logic [OW-1:0] arch [RW];

   // Pipeline slots indexed 0 decode, 1 execute, 2 ctrl and 3 writeback
   logic [AW-1:0] slot_rd  [4];
   logic          slot_we  [4];
   logic [OW-1:0] slot_res [4];

   rf_bypass_top #(
      .RF_ADDR_WIDTH (AW),
      .RF_WORDS      (RW),
      .OPERAND_WIDTH (OW)
   ) UUT (
      .clk               (clk),
      .rst               (rst),
      .padv_decode_i     (padv_decode_i),
      .decode_valid_i    (decode_valid_i),
      .pipeline_flush_i  (pipeline_flush_i),
      .decode_rfa_adr_i  (decode_rfa_adr_i),
      .decode_rfb_adr_i  (decode_rfb_adr_i),
      .execute_rfd_adr_i (execute_rfd_adr_i),
      .execute_rf_wb_i   (execute_rf_wb_i),
      .ctrl_rfd_adr_i    (ctrl_rfd_adr_i),
      .ctrl_rf_wb_i      (ctrl_rf_wb_i),
      .wb_rfd_adr_i      (wb_rfd_adr_i),
      .wb_rf_wb_i        (wb_rf_wb_i),
      .ctrl_alu_result_i (ctrl_alu_result_i),
      .wb_result_i       (wb_result_i),
      .execute_rfa_o     (execute_rfa_o),
      .execute_rfb_o     (execute_rfb_o)
   );

   always #50 clk = ~clk;

   // Move to the drive point just after the next rising edge
   task automatic next_cycle();
      @(posedge clk);
      #5;
   endtask

   function automatic logic [OW-1:0] rand_word();
      return $random(seed);
   endfunction

   // Source register for one port biased toward a later stage
   function automatic logic [AW-1:0] choose_src(input int mode);
      logic [AW-1:0] r;
      case (mode)
         1: r = slot_rd[1];
         2: r = ($random(seed) & 1) ? slot_rd[2] : slot_rd[3];
         3: r = slot_rd[3];
         default: r = $random(seed) % RW;
      endcase
      return r;
   endfunction

   // Forwarding priority is execute, ctrl, writeback and then the register file
   function automatic logic [OW-1:0] predict_operand(input logic [AW-1:0] r);
      if (!flushing_m && slot_we[1] && slot_rd[1] == r) begin
         return slot_res[1];
      end else if (slot_we[2] && slot_rd[2] == r) begin
         return slot_res[2];
      end else if (slot_we[3] && slot_rd[3] == r) begin
         return slot_res[3];
      end
      return arch[r];
   endfunction

   task automatic check_operands(input logic [AW-1:0] ra, input logic [AW-1:0] rb,
                                 input logic [OW-1:0] ea, input logic [OW-1:0] eb);
      assert (execute_rfa_o === ea) else begin
         $display("MISMATCH at %0t: port a reg %0d expected %h actual %h",
                  $time, ra, ea, execute_rfa_o);
         errors++;
      end
      assert (execute_rfb_o === eb) else begin
         $display("MISMATCH at %0t: port b reg %0d expected %h actual %h",
                  $time, rb, eb, execute_rfb_o);
         errors++;
      end
   endtask

   // Drive the later stages from the model slots
   task automatic drive_stages();
      execute_rfd_adr_i = slot_rd[1];
      execute_rf_wb_i   = slot_we[1];
      ctrl_rfd_adr_i    = slot_rd[2];
      ctrl_rf_wb_i      = slot_we[2];
      wb_rfd_adr_i      = slot_rd[3];
      ctrl_alu_result_i = slot_res[2];
      wb_result_i       = slot_res[3];
   endtask

   // One instruction with an optional flush, the advance, the check and stall cycles
   // Dest mode 0 writes nothing, 1 random register, 2 one of two registers
   task automatic step(input int src_mode, input int dest_mode,
                       input bit flush_first, input int stalls);
      logic [AW-1:0] ra;
      logic [AW-1:0] rb;
      logic [OW-1:0] ea;
      logic [OW-1:0] eb;
      if (flush_first) begin
         pipeline_flush_i = 1'b1;
         next_cycle();
         pipeline_flush_i = 1'b0;
         flushing_m = 1'b1;
      end
      ra = choose_src(src_mode);
      rb = choose_src(src_mode);
      slot_rd[0]  = (dest_mode == 2) ? AW'(1 + ($random(seed) & 1)) : AW'($random(seed));
      slot_we[0]  = (dest_mode != 0);
      slot_res[0] = rand_word();
      // Writeback retires at the same edge as the advance
      padv_decode_i    = 1'b1;
      decode_valid_i   = 1'b1;
      decode_rfa_adr_i = ra;
      decode_rfb_adr_i = rb;
      drive_stages();
      wb_rf_wb_i = slot_we[3];
      if (slot_we[3]) begin
         arch[slot_rd[3]] = slot_res[3];
      end
      ea = predict_operand(ra);
      eb = predict_operand(rb);
      next_cycle();
      flushing_m = 1'b0;
      for (int i = 3; i > 0; i--) begin
         slot_rd[i]  = slot_rd[i-1];
         slot_we[i]  = slot_we[i-1];
         slot_res[i] = slot_res[i-1];
      end
      padv_decode_i = 1'b0;
      drive_stages();
      wb_rf_wb_i = 1'b0;
      #45;
      check_operands(ra, rb, ea, eb);
      // Stalled cycles with live results moving underneath
      for (int s = 0; s < stalls; s++) begin
         next_cycle();
         decode_valid_i    = 1'b0;
         ctrl_alu_result_i = rand_word();
         wb_result_i       = rand_word();
         // Decode already looks at other registers while the advance is held
         decode_rfa_adr_i  = AW'($random(seed));
         decode_rfb_adr_i  = AW'($random(seed));
         #45;
         check_operands(ra, rb, ea, eb);
      end
      next_cycle();
      decode_valid_i = 1'b1;
   endtask

   task automatic run_test(input string name, input int src_mode, input int dest_mode,
                           input bit flush_first, input int stalls, input int count);
      int errors_before;
      errors_before = errors;
      for (int n = 0; n < count; n++) begin
         step(src_mode, dest_mode, flush_first, stalls);
      end
      if (errors == errors_before) begin
         tests_passed++;
         $display("test %s: passed", name);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d mismatches", name, errors - errors_before);
      end
   endtask

   initial begin
      #(RUN_LIMIT);
      $display("Simulation did not finish within the time limit");
      $display("TEST RESULT: FAIL");
      $finish;
   end

   initial begin
      seed = 91713;
      errors = 0;
      tests_passed = 0;
      tests_failed = 0;
      flushing_m = 1'b0;
      clk = 1'b0;
      rst = 1'b1;
      padv_decode_i = 1'b0;
      decode_valid_i = 1'b0;
      pipeline_flush_i = 1'b0;
      decode_rfa_adr_i = '0;
      decode_rfb_adr_i = '0;
      wb_rf_wb_i = 1'b0;
      for (int i = 0; i < RW; i++) begin
         arch[i] = '0;
      end
      for (int i = 0; i < 4; i++) begin
         slot_rd[i]  = '0;
         slot_we[i]  = 1'b0;
         slot_res[i] = '0;
      end
      drive_stages();
      repeat (2) @(posedge clk);
      #5;
      rst = 1'b0;
      decode_valid_i = 1'b1;
      next_cycle();

      run_test("ram_read", 0, 0, 1'b0, 0, 12);
      run_test("execute_priority", 1, 2, 1'b0, 0, 12);
      run_test("ctrl_wb_forward", 2, 1, 1'b0, 0, 16);
      run_test("stall_hold", 1, 1, 1'b0, 3, 8);
      run_test("flush_masks_execute", 1, 1, 1'b1, 0, 8);
      run_test("writeback_through", 3, 1, 1'b0, 0, 8);
      run_test("mixed_random", 0, 2, 1'b0, 2, 16);

      $display("tests passed %0d, failed %0d, mismatches %0d",
               tests_passed, tests_failed, errors);
      if (tests_failed == 0 && errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* tb/rf_bypass_properties.sv */
// Concurrent checks on the bypass top level, attached with bind.
// Covers the source encoding after reset, the masked execute match after a
// flush and operand stability over a stall.

module rf_bypass_properties #(
   parameter int unsigned OPERAND_WIDTH = rf_pkg::OPERAND_WIDTH_DEF
) (
   input logic                     clk,
   input logic                     rst,
   input logic                     padv_decode_i,
   input logic                     decode_valid_i,
   input logic                     pipeline_flush_i,
   input logic                     flushing,
   input rf_pkg::fwd_src_e         src_a,
   input rf_pkg::fwd_src_e         src_b,
   input logic [OPERAND_WIDTH-1:0] execute_rfa_o,
   input logic [OPERAND_WIDTH-1:0] execute_rfb_o
);
   timeunit 1ns;
   timeprecision 1ps;

   // Hazard flags come out of reset cleared
   property reset_sources_ram;
      @(posedge clk)
      $fell(rst) |-> (src_a == rf_pkg::FWD_RAM) && (src_b == rf_pkg::FWD_RAM);
   endproperty

   // Advance inside the flush window never picks the execute result
   property flush_masks_execute;
      @(posedge clk) disable iff (rst)
      (padv_decode_i && flushing) |=>
         (src_a != rf_pkg::FWD_EXECUTE) && (src_b != rf_pkg::FWD_EXECUTE);
   endproperty

   // Two stalled cycles in a row keep both operands
   property stall_holds_operands;
      @(posedge clk) disable iff (rst)
      (!padv_decode_i && !decode_valid_i && !pipeline_flush_i &&
       $past(!padv_decode_i && !decode_valid_i && !pipeline_flush_i))
         |-> $stable(execute_rfa_o) && $stable(execute_rfb_o);
   endproperty

   assert property (reset_sources_ram)
      else $error("operand sources not RAM after reset");

   assert property (flush_masks_execute)
      else $error("execute forwarding selected after a flushed advance");

   assert property (stall_holds_operands)
      else $error("operands changed during a stall");

endmodule

bind rf_bypass_top rf_bypass_properties #(
   .OPERAND_WIDTH (OPERAND_WIDTH)
) u_properties (
   .clk              (clk),
   .rst              (rst),
   .padv_decode_i    (padv_decode_i),
   .decode_valid_i   (decode_valid_i),
   .pipeline_flush_i (pipeline_flush_i),
   .flushing         (u_hazard_tracker.flushing),
   .src_a            (src_a),
   .src_b            (src_b),
   .execute_rfa_o    (execute_rfa_o),
   .execute_rfb_o    (execute_rfb_o)
);

/* verilog/rf_bypass_top.sv */
// Operand register file with result bypassing for a five-stage pipeline.
// Two RAM banks supply the architectural values, the hazard tracker supplies
// the forwarding sources and held results, and the selector merges them into
// the two execute operands, valid the cycle after each decode advance.

module rf_bypass_top #(
   parameter int unsigned RF_ADDR_WIDTH = rf_pkg::RF_ADDR_WIDTH_DEF,
   parameter int unsigned RF_WORDS      = rf_pkg::RF_WORDS_DEF,
   parameter int unsigned OPERAND_WIDTH = rf_pkg::OPERAND_WIDTH_DEF
) (
   input  logic                     clk,
   input  logic                     rst,

   // Pipeline control
   input  logic                     padv_decode_i,
   input  logic                     decode_valid_i,
   input  logic                     pipeline_flush_i,

   // Decode source registers
   input  logic [RF_ADDR_WIDTH-1:0] decode_rfa_adr_i,
   input  logic [RF_ADDR_WIDTH-1:0] decode_rfb_adr_i,

   // Destinations and write flags of the later stages
   input  logic [RF_ADDR_WIDTH-1:0] execute_rfd_adr_i,
   input  logic                     execute_rf_wb_i,
   input  logic [RF_ADDR_WIDTH-1:0] ctrl_rfd_adr_i,
   input  logic                     ctrl_rf_wb_i,
   input  logic [RF_ADDR_WIDTH-1:0] wb_rfd_adr_i,
   input  logic                     wb_rf_wb_i,

   // Results
   input  logic [OPERAND_WIDTH-1:0] ctrl_alu_result_i,
   input  logic [OPERAND_WIDTH-1:0] wb_result_i,

   // Execute operands
   output logic [OPERAND_WIDTH-1:0] execute_rfa_o,
   output logic [OPERAND_WIDTH-1:0] execute_rfb_o
);

   // RAM read data
   logic [OPERAND_WIDTH-1:0] ram_a;
   logic [OPERAND_WIDTH-1:0] ram_b;

   // Forwarding sources and values
   rf_pkg::fwd_src_e         src_a;
   rf_pkg::fwd_src_e         src_b;
   logic [OPERAND_WIDTH-1:0] execute_fwd;
   logic [OPERAND_WIDTH-1:0] ctrl_fwd;
   logic [OPERAND_WIDTH-1:0] wb_fwd;

   // Bank for source A, writeback goes to both banks
   rf_ram #(
      .RF_ADDR_WIDTH (RF_ADDR_WIDTH),
      .RF_WORDS      (RF_WORDS),
      .OPERAND_WIDTH (OPERAND_WIDTH)
   ) rfa (
      .clk    (clk),
      .rst    (rst),
      .rdad_i (decode_rfa_adr_i),
      .rden_i (padv_decode_i),
      .rdda_o (ram_a),
      .wrad_i (wb_rfd_adr_i),
      .wren_i (wb_rf_wb_i),
      .wrda_i (wb_result_i)
   );

   // Bank for source B, also read on the decode advance
   rf_ram #(
      .RF_ADDR_WIDTH (RF_ADDR_WIDTH),
      .RF_WORDS      (RF_WORDS),
      .OPERAND_WIDTH (OPERAND_WIDTH)
   ) rfb (
      .clk    (clk),
      .rst    (rst),
      .rdad_i (decode_rfb_adr_i),
      .rden_i (padv_decode_i),
      .rdda_o (ram_b),
      .wrad_i (wb_rfd_adr_i),
      .wren_i (wb_rf_wb_i),
      .wrda_i (wb_result_i)
   );

   hazard_tracker #(
      .RF_ADDR_WIDTH (RF_ADDR_WIDTH),
      .OPERAND_WIDTH (OPERAND_WIDTH)
   ) u_hazard_tracker (
      .clk               (clk),
      .rst               (rst),
      .padv_decode_i     (padv_decode_i),
      .decode_valid_i    (decode_valid_i),
      .pipeline_flush_i  (pipeline_flush_i),
      .decode_rfa_adr_i  (decode_rfa_adr_i),
      .decode_rfb_adr_i  (decode_rfb_adr_i),
      .execute_rfd_adr_i (execute_rfd_adr_i),
      .execute_rf_wb_i   (execute_rf_wb_i),
      .ctrl_rfd_adr_i    (ctrl_rfd_adr_i),
      .ctrl_rf_wb_i      (ctrl_rf_wb_i),
      .wb_rfd_adr_i      (wb_rfd_adr_i),
      .wb_rf_wb_i        (wb_rf_wb_i),
      .ctrl_alu_result_i (ctrl_alu_result_i),
      .wb_result_i       (wb_result_i),
      .src_a_o           (src_a),
      .src_b_o           (src_b),
      .execute_fwd_o     (execute_fwd),
      .ctrl_fwd_o        (ctrl_fwd),
      .wb_fwd_o          (wb_fwd)
   );

   operand_select #(
      .OPERAND_WIDTH (OPERAND_WIDTH)
   ) u_operand_select (
      .src_a_i       (src_a),
      .src_b_i       (src_b),
      .execute_fwd_i (execute_fwd),
      .ctrl_fwd_i    (ctrl_fwd),
      .wb_fwd_i      (wb_fwd),
      .ram_a_i       (ram_a),
      .ram_b_i       (ram_b),
      .execute_rfa_o (execute_rfa_o),
      .execute_rfb_o (execute_rfb_o)
   );

endmodule

/* verilog/operand_select.sv */
// Operand selector for the execute stage.
// Picks each operand from one of the three forwarded results or from its RAM
// bank, as directed by the source from the hazard tracker. Purely
// combinational, a registered variant can take its place at the top level.

module operand_select #(
   parameter int unsigned OPERAND_WIDTH = rf_pkg::OPERAND_WIDTH_DEF
) (
   // Sources per port
   input  rf_pkg::fwd_src_e         src_a_i,
   input  rf_pkg::fwd_src_e         src_b_i,

   // Forwarded results, shared by both ports
   input  logic [OPERAND_WIDTH-1:0] execute_fwd_i,
   input  logic [OPERAND_WIDTH-1:0] ctrl_fwd_i,
   input  logic [OPERAND_WIDTH-1:0] wb_fwd_i,

   // Architectural values from the RAM banks
   input  logic [OPERAND_WIDTH-1:0] ram_a_i,
   input  logic [OPERAND_WIDTH-1:0] ram_b_i,

   // Execute operands
   output logic [OPERAND_WIDTH-1:0] execute_rfa_o,
   output logic [OPERAND_WIDTH-1:0] execute_rfb_o
);

   // Four-way choice for one port
   function automatic logic [OPERAND_WIDTH-1:0] pick(
      input rf_pkg::fwd_src_e         src,
      input logic [OPERAND_WIDTH-1:0] exe_val,
      input logic [OPERAND_WIDTH-1:0] ctrl_val,
      input logic [OPERAND_WIDTH-1:0] wb_val,
      input logic [OPERAND_WIDTH-1:0] ram_val
   );
      logic [OPERAND_WIDTH-1:0] val;
      case (src)
         rf_pkg::FWD_EXECUTE: val = exe_val;
         rf_pkg::FWD_CTRL:    val = ctrl_val;
         rf_pkg::FWD_WB:      val = wb_val;
         // No pending write
         default:             val = ram_val;
      endcase
      return val;
   endfunction

   // Port A
   assign execute_rfa_o = pick(src_a_i, execute_fwd_i, ctrl_fwd_i, wb_fwd_i, ram_a_i);

   // Port B
   assign execute_rfb_o = pick(src_b_i, execute_fwd_i, ctrl_fwd_i, wb_fwd_i, ram_b_i);

endmodule

/* verilog/hazard_tracker.sv */
// Hazard tracker for the execute operands.
// On each decode advance it compares both decode source registers with the
// destinations of the instructions in execute, ctrl and writeback, and it
// encodes the matches into a forwarding source per port. It also supplies the
// forwarded results, held steady while the pipeline is stalled.

module hazard_tracker #(
   parameter int unsigned RF_ADDR_WIDTH = rf_pkg::RF_ADDR_WIDTH_DEF,
   parameter int unsigned OPERAND_WIDTH = rf_pkg::OPERAND_WIDTH_DEF
) (
   input  logic                     clk,
   input  logic                     rst,

   // Pipeline control
   input  logic                     padv_decode_i,
   input  logic                     decode_valid_i,
   input  logic                     pipeline_flush_i,

   // Decode source registers
   input  logic [RF_ADDR_WIDTH-1:0] decode_rfa_adr_i,
   input  logic [RF_ADDR_WIDTH-1:0] decode_rfb_adr_i,

   // Destinations and write flags of the later stages
   input  logic [RF_ADDR_WIDTH-1:0] execute_rfd_adr_i,
   input  logic                     execute_rf_wb_i,
   input  logic [RF_ADDR_WIDTH-1:0] ctrl_rfd_adr_i,
   input  logic                     ctrl_rf_wb_i,
   input  logic [RF_ADDR_WIDTH-1:0] wb_rfd_adr_i,
   input  logic                     wb_rf_wb_i,

   // Results to forward
   input  logic [OPERAND_WIDTH-1:0] ctrl_alu_result_i,
   input  logic [OPERAND_WIDTH-1:0] wb_result_i,

   // Forwarding sources and values
   output rf_pkg::fwd_src_e         src_a_o,
   output rf_pkg::fwd_src_e         src_b_o,
   output logic [OPERAND_WIDTH-1:0] execute_fwd_o,
   output logic [OPERAND_WIDTH-1:0] ctrl_fwd_o,
   output logic [OPERAND_WIDTH-1:0] wb_fwd_o
);

   // Set after a flush until the next decode advance
   // The execute stage holds no valid instruction in that window
   logic flushing;

   // Match flags per stage and port
   logic execute_hazard_a;
   logic execute_hazard_b;
   logic ctrl_hazard_a;
   logic ctrl_hazard_b;
   logic wb_hazard_a;
   logic wb_hazard_b;

   // Results saved for a stall
   logic [OPERAND_WIDTH-1:0] execute_result_r;
   logic [OPERAND_WIDTH-1:0] ctrl_result_r;

   // Priority encode one port: execute, ctrl, writeback, then RAM
   function automatic rf_pkg::fwd_src_e encode_src(input logic exe_hit,
                                                   input logic ctrl_hit,
                                                   input logic wb_hit);
      if (exe_hit) begin
         return rf_pkg::FWD_EXECUTE;
      end else if (ctrl_hit) begin
         return rf_pkg::FWD_CTRL;
      end else if (wb_hit) begin
         return rf_pkg::FWD_WB;
      end
      return rf_pkg::FWD_RAM;
   endfunction

   always_ff @(posedge clk) begin
      if (rst) begin
         flushing <= 1'b0;
      end else if (pipeline_flush_i) begin
         flushing <= 1'b1;
      end else if (padv_decode_i) begin
         flushing <= 1'b0;
      end
   end

   // Execute matches, masked while the execute stage is flushed
   always_ff @(posedge clk) begin
      if (rst || pipeline_flush_i) begin
         execute_hazard_a <= 1'b0;
         execute_hazard_b <= 1'b0;
      end else if (padv_decode_i) begin
         execute_hazard_a <= !flushing && execute_rf_wb_i &&
                             (execute_rfd_adr_i == decode_rfa_adr_i);
         execute_hazard_b <= !flushing && execute_rf_wb_i &&
                             (execute_rfd_adr_i == decode_rfb_adr_i);
      end
   end

   // Ctrl and writeback matches, sampled on every advance
   always_ff @(posedge clk) begin
      if (rst) begin
         ctrl_hazard_a <= 1'b0;
         ctrl_hazard_b <= 1'b0;
         wb_hazard_a   <= 1'b0;
         wb_hazard_b   <= 1'b0;
      end else if (padv_decode_i) begin
         ctrl_hazard_a <= ctrl_rf_wb_i && (ctrl_rfd_adr_i == decode_rfa_adr_i);
         ctrl_hazard_b <= ctrl_rf_wb_i && (ctrl_rfd_adr_i == decode_rfb_adr_i);
         wb_hazard_a   <= wb_rf_wb_i && (wb_rfd_adr_i == decode_rfa_adr_i);
         wb_hazard_b   <= wb_rf_wb_i && (wb_rfd_adr_i == decode_rfb_adr_i);
      end
   end

   // Track live results while valid, keep the last one over a stall
   always_ff @(posedge clk) begin
      if (decode_valid_i) begin
         execute_result_r <= ctrl_alu_result_i;
         ctrl_result_r    <= wb_result_i;
      end
   end

   // The writeback result leaves the pipeline at the advance
   always_ff @(posedge clk) begin
      if (rst) begin
         wb_fwd_o <= '0;
      end else if (padv_decode_i) begin
         wb_fwd_o <= wb_result_i;
      end
   end

   assign execute_fwd_o = decode_valid_i ? ctrl_alu_result_i : execute_result_r;
   assign ctrl_fwd_o    = decode_valid_i ? wb_result_i : ctrl_result_r;

   assign src_a_o = encode_src(execute_hazard_a, ctrl_hazard_a, wb_hazard_a);
   assign src_b_o = encode_src(execute_hazard_b, ctrl_hazard_b, wb_hazard_b);

endmodule

/* rf_ram/rf_ram.sv */
// One-read, one-write register RAM for the operand register file.
// The read port is registered and only updates while rden_i is high, so the
// output holds across pipeline stalls. A write to the address being read in
// the same cycle is passed through to the read data.

module rf_ram #(
   parameter int unsigned RF_ADDR_WIDTH = rf_pkg::RF_ADDR_WIDTH_DEF,
   parameter int unsigned RF_WORDS      = rf_pkg::RF_WORDS_DEF,
   parameter int unsigned OPERAND_WIDTH = rf_pkg::OPERAND_WIDTH_DEF
) (
   input  logic                     clk,
   input  logic                     rst,

   // Read port
   input  logic [RF_ADDR_WIDTH-1:0] rdad_i,
   input  logic                     rden_i,
   output logic [OPERAND_WIDTH-1:0] rdda_o,

   // Write port
   input  logic [RF_ADDR_WIDTH-1:0] wrad_i,
   input  logic                     wren_i,
   input  logic [OPERAND_WIDTH-1:0] wrda_i
);

   // Register storage
   logic [OPERAND_WIDTH-1:0] mem [RF_WORDS];

   // Same-address write during a read
   logic write_through;

   // All registers start at zero
   initial begin
      for (int i = 0; i < RF_WORDS; i++) begin
         mem[i] = '0;
      end
   end

   assign write_through = wren_i && (wrad_i == rdad_i);

   // Write port
   always @(posedge clk) begin
      if (wren_i) begin
         mem[wrad_i] <= wrda_i;
      end
   end

   // Registered read
   // New data wins over the stored word when both hit one address
   always_ff @(posedge clk) begin
      if (rst) begin
         rdda_o <= '0;
      end else if (rden_i) begin
         if (write_through) begin
            rdda_o <= wrda_i;
         end else begin
            rdda_o <= mem[rdad_i];
         end
      end
   end

endmodule

/* common/rf_pkg.sv */
// Shared definitions for the operand register file and its bypass network.
// Holds the default widths that the top level feeds into its parameters and
// the encoding of where an execute operand comes from.
// Referenced by scoped name from the RTL and the testbench.

package rf_pkg;

   // Default width of a register number
   parameter int unsigned RF_ADDR_WIDTH_DEF = 5;

   // Default number of architectural registers
   parameter int unsigned RF_WORDS_DEF = 32;

   // Default width of one operand
   parameter int unsigned OPERAND_WIDTH_DEF = 32;

   // Source of an execute operand
   // Priority from high to low is execute, ctrl, writeback, RAM
   typedef enum logic [1:0] {
      // No pending write, architectural value from the RAM bank
      FWD_RAM     = 2'd0,
      // Result of the instruction one stage ahead
      FWD_EXECUTE = 2'd1,
      // Result of the instruction two stages ahead
      FWD_CTRL    = 2'd2,
      // Writeback result captured at the decode advance
      FWD_WB      = 2'd3
   } fwd_src_e;

endpackage
